/* hdl/rv32i_lsu_pkg.sv */
package rv32i_lsu_pkg;

        // reorder buffer tag and queue sizing
        localparam int ROB_IDX_W   = 4;
        localparam int QUEUE_DEPTH = 4;
        localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
        localparam int QCNT_W      = $clog2(QUEUE_DEPTH + 1);
        localparam int WB_DEPTH    = 2;

        // rv32i major opcodes for memory ops
        localparam logic [6:0] op_b_load  = 7'b0000011;
        localparam logic [6:0] op_b_store = 7'b0100011;

        // funct3 of loads and stores
        typedef enum logic [2:0] {
                mem_op_b  = 3'b000,
                mem_op_h  = 3'b001,
                mem_op_w  = 3'b010,
                mem_op_bu = 3'b100,
                mem_op_hu = 3'b101
        } mem_op_t;

        // one instruction word, read as I-type for loads or S-type for stores
        typedef union packed {
                struct packed {
                        logic [11:0] imm;
                        logic [4:0]  rs1;
                        mem_op_t     funct3;
                        logic [4:0]  rd;
                        logic [6:0]  opcode;
                } i_load;
                struct packed {
                        logic [6:0]  imm_hi;
                        logic [4:0]  rs2;
                        logic [4:0]  rs1;
                        mem_op_t     funct3;
                        logic [4:0]  imm_lo;
                        logic [6:0]  opcode;
                } s_store;
        } rv32i_inst_t;

        typedef struct packed {
                logic [31:0]          pc;
                logic                 is_load;
                logic                 is_store;
                mem_op_t              memop;
                logic [31:0]          rs1_data;
                logic [31:0]          imm_sext;
                logic [31:0]          rs2_data;
                logic [4:0]           rd_addr;
                logic [ROB_IDX_W-1:0] rob_idx;
        } mem_entry_t;

        typedef struct packed {
                logic [ROB_IDX_W-1:0] rob_idx;
                logic [4:0]           rd_addr;
                logic                 regf_we;
                logic [31:0]          rd_data;
                logic [31:0]          mem_addr;
                logic                 is_store;
        } lsu_result_t;

endpackage

/* hdl/lsu_ifs.sv */
`timescale 1ns/1ps

// issue queue head toward the memory unit
interface mem_issue_if
        import rv32i_lsu_pkg::*;
        ();

        logic       valid;
        logic       ready;
        mem_entry_t entry;

        modport src (
                output valid,
                output entry,
                input  ready
        );

        modport dst (
                input  valid,
                input  entry,
                output ready
        );

endinterface

// finished ops toward the writeback buffer
interface lsu_result_if
        import rv32i_lsu_pkg::*;
        ();

        logic        valid;
        logic        ready;
        lsu_result_t result;

        modport src (output valid, output result, input ready);
        modport dst (input valid, input result, output ready);

endinterface

/* hdl/mem_issue_queue.sv */
`timescale 1ns/1ps

module mem_issue_queue
        import rv32i_lsu_pkg::*;
        (
        input  logic                 clk,
        input  logic                 rst,
        input  logic                 in_valid,
        output logic                 in_ready,
        input  logic [31:0]          in_pc,
        input  logic [31:0]          in_inst,
        input  logic [31:0]          in_rs1_data,
        input  logic [31:0]          in_rs2_data,
        input  logic [4:0]           in_rd_addr,
        input  logic [ROB_IDX_W-1:0] in_rob_idx,
        mem_issue_if.src             issue
);

        rv32i_inst_t inst;
        mem_entry_t  dec;
        mem_entry_t  slots [QUEUE_DEPTH];
        logic [QPTR_W-1:0] wr_ptr;
        logic [QPTR_W-1:0] rd_ptr;
        logic [QCNT_W-1:0] count;
        logic push;
        logic pop;

        assign inst = in_inst;

        // decode, view picked by opcode
        always_comb begin
                dec          = '0;
                dec.pc       = in_pc;
                dec.rs1_data = in_rs1_data;
                dec.rs2_data = in_rs2_data;
                dec.rob_idx  = in_rob_idx;
                dec.is_load  = (inst.i_load.opcode == op_b_load);
                dec.is_store = (inst.s_store.opcode == op_b_store);
                if (dec.is_store) begin
                        dec.imm_sext = {{20{inst.s_store.imm_hi[6]}},
                                        inst.s_store.imm_hi, inst.s_store.imm_lo};
                        dec.memop    = inst.s_store.funct3;
                        // stores never write the register file
                        dec.rd_addr  = '0;
                end else begin
                        dec.imm_sext = {{20{inst.i_load.imm[11]}}, inst.i_load.imm};
                        dec.memop    = inst.i_load.funct3;
                        dec.rd_addr  = in_rd_addr;
                end
        end

        assign in_ready    = (count != QCNT_W'(QUEUE_DEPTH));
        assign push        = in_valid && in_ready;
        assign pop         = issue.valid && issue.ready;
        assign issue.valid = (count != '0);
        assign issue.entry = slots[rd_ptr];

        always_ff @(posedge clk) begin
                if (rst) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        count  <= '0;
                end else begin
                        if (push)
                                wr_ptr <= wr_ptr + 1'b1;
                        if (pop)
                                rd_ptr <= rd_ptr + 1'b1;
                        if (push && !pop)
                                count <= count + 1'b1;
                        else if (pop && !push)
                                count <= count - 1'b1;
                end
        end

        always_ff @(posedge clk) begin
                if (push)
                        slots[wr_ptr] <= dec;
        end

endmodule

/* hdl/mem_unit.sv */
`timescale 1ns/1ps

module mem_unit
        import rv32i_lsu_pkg::*;
        (
        input  logic        clk,
        input  logic        rst,
        mem_issue_if.dst    issue,

        output logic [31:0] dmem_addr,
        output logic [3:0]  dmem_rmask,
        output logic [3:0]  dmem_wmask,
        output logic [31:0] dmem_wdata,
        input  logic [31:0] dmem_rdata,
        input  logic        dmem_resp,

        lsu_result_if.src   result
);

        logic        req_pending;
        logic        res_valid;
        logic        take;
        logic        resp_hit;
        logic [31:0] eff_addr;
        logic [3:0]  width_mask;
        mem_entry_t  cur_entry;
        // effective address of the op in flight, low bits are the byte offset
        logic [31:0] cur_addr;
        logic [31:0] rdata_shifted;
        logic [31:0] load_data;
        lsu_result_t next_res;
        lsu_result_t res;

        // one op at a time, nothing new while a result waits
        assign issue.ready = !req_pending && !res_valid;
        assign take        = issue.valid && issue.ready;
        assign resp_hit    = req_pending && dmem_resp;
        assign eff_addr    = issue.entry.rs1_data + issue.entry.imm_sext;

        always_comb begin
                case (issue.entry.memop)
                        mem_op_b, mem_op_bu: width_mask = 4'b0001;
                        mem_op_h, mem_op_hu: width_mask = 4'b0011;
                        default:             width_mask = 4'b1111;
                endcase
        end

        // bring the accessed bytes down to bit 0, then extend
        assign rdata_shifted = dmem_rdata >> {cur_addr[1:0], 3'b000};

        always_comb begin
                case (cur_entry.memop)
                        mem_op_b:  load_data = {{24{rdata_shifted[7]}}, rdata_shifted[7:0]};
                        mem_op_h:  load_data = {{16{rdata_shifted[15]}}, rdata_shifted[15:0]};
                        mem_op_bu: load_data = {24'b0, rdata_shifted[7:0]};
                        mem_op_hu: load_data = {16'b0, rdata_shifted[15:0]};
                        default:   load_data = rdata_shifted;
                endcase
        end

        always_comb begin
                next_res          = '0;
                next_res.rob_idx  = cur_entry.rob_idx;
                next_res.rd_addr  = cur_entry.rd_addr;
                next_res.regf_we  = cur_entry.is_load && (cur_entry.rd_addr != '0);
                next_res.rd_data  = cur_entry.is_load ? load_data : '0;
                next_res.mem_addr = cur_addr;
                next_res.is_store = cur_entry.is_store;
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        req_pending <= 1'b0;
                        res_valid   <= 1'b0;
                        dmem_addr   <= '0;
                        dmem_rmask  <= '0;
                        dmem_wmask  <= '0;
                end else if (take) begin
                        req_pending <= 1'b1;
                        dmem_addr   <= {eff_addr[31:2], 2'b00};
                        if (issue.entry.is_load)
                                dmem_rmask <= width_mask << eff_addr[1:0];
                        else
                                dmem_wmask <= width_mask << eff_addr[1:0];
                end else if (resp_hit) begin
                        // request ends, result waits for the buffer
                        req_pending <= 1'b0;
                        res_valid   <= 1'b1;
                        dmem_rmask  <= '0;
                        dmem_wmask  <= '0;
                end else if (res_valid && result.ready) begin
                        res_valid <= 1'b0;
                end
        end

        always_ff @(posedge clk) begin
                if (take) begin
                        cur_entry  <= issue.entry;
                        cur_addr   <= eff_addr;
                        dmem_wdata <= issue.entry.rs2_data << {eff_addr[1:0], 3'b000};
                end
                if (resp_hit)
                        res <= next_res;
        end

        assign result.valid  = res_valid;
        assign result.result = res;

endmodule

/* hdl/wb_buffer.sv */
`timescale 1ns/1ps

module wb_buffer
        import rv32i_lsu_pkg::*;
        (
        input  logic                 clk,
        input  logic                 rst,
        lsu_result_if.dst            result,
        output logic                 wb_valid,
        input  logic                 wb_ready,
        output logic [ROB_IDX_W-1:0] wb_rob_idx,
        output logic [4:0]           wb_rd_addr,
        output logic                 wb_regf_we,
        output logic [31:0]          wb_rd_data,
        output logic [31:0]          wb_mem_addr,
        output logic                 wb_is_store
);

        lsu_result_t slots [WB_DEPTH];
        logic        wr_ptr;
        logic        rd_ptr;
        logic [1:0]  count;
        logic        push;
        logic        pop;
        lsu_result_t head;

        // ready only from the registered count, no path from wb_ready
        assign result.ready = (count != 2'(WB_DEPTH));
        assign push         = result.valid && result.ready;
        assign pop          = wb_valid && wb_ready;
        assign wb_valid     = (count != '0);
        assign head         = slots[rd_ptr];

        always_ff @(posedge clk) begin
                if (rst) begin
                        wr_ptr <= 1'b0;
                        rd_ptr <= 1'b0;
                        count  <= '0;
                end else begin
                        wr_ptr <= wr_ptr ^ push;
                        rd_ptr <= rd_ptr ^ pop;
                        count  <= count + {1'b0, push} - {1'b0, pop};
                end
        end

        always_ff @(posedge clk) begin
                if (push)
                        slots[wr_ptr] <= result.result;
        end

        assign wb_rob_idx  = head.rob_idx;
        assign wb_rd_addr  = head.rd_addr;
        assign wb_regf_we  = head.regf_we;
        assign wb_rd_data  = head.rd_data;
        assign wb_mem_addr = head.mem_addr;
        assign wb_is_store = head.is_store;

endmodule

/* hdl/lsu_top.sv */
`timescale 1ns/1ps

module lsu_top
        import rv32i_lsu_pkg::*;
        (
        input  logic                 clk,
        input  logic                 rst,

        // from the reservation stations
        input  logic                 iss_valid,
        output logic                 iss_ready,
        input  logic [31:0]          iss_pc,
        input  logic [31:0]          iss_inst,
        input  logic [31:0]          iss_rs1_data,
        input  logic [31:0]          iss_rs2_data,
        input  logic [4:0]           iss_rd_addr,
        input  logic [ROB_IDX_W-1:0] iss_rob_idx,

        // data memory
        output logic [31:0]          dmem_addr,
        output logic [3:0]           dmem_rmask,
        output logic [3:0]           dmem_wmask,
        output logic [31:0]          dmem_wdata,
        input  logic [31:0]          dmem_rdata,
        input  logic                 dmem_resp,

        // toward commit and writeback
        output logic                 wb_valid,
        input  logic                 wb_ready,
        output logic [ROB_IDX_W-1:0] wb_rob_idx,
        output logic [4:0]           wb_rd_addr,
        output logic                 wb_regf_we,
        output logic [31:0]          wb_rd_data,
        output logic [31:0]          wb_mem_addr,
        output logic                 wb_is_store
);

        mem_issue_if  issue_bus ();
        lsu_result_if result_bus ();

        mem_issue_queue u_queue (
                .clk         (clk),
                .rst         (rst),
                .in_valid    (iss_valid),
                .in_ready    (iss_ready),
                .in_pc       (iss_pc),
                .in_inst     (iss_inst),
                .in_rs1_data (iss_rs1_data),
                .in_rs2_data (iss_rs2_data),
                .in_rd_addr  (iss_rd_addr),
                .in_rob_idx  (iss_rob_idx),
                .issue       (issue_bus.src)
        );

        mem_unit u_mem (
                .clk        (clk),
                .rst        (rst),
                .issue      (issue_bus.dst),
                .dmem_addr  (dmem_addr),
                .dmem_rmask (dmem_rmask),
                .dmem_wmask (dmem_wmask),
                .dmem_wdata (dmem_wdata),
                .dmem_rdata (dmem_rdata),
                .dmem_resp  (dmem_resp),
                .result     (result_bus.src)
        );

        wb_buffer u_wb (
                .clk         (clk),
                .rst         (rst),
                .result      (result_bus.dst),
                .wb_valid    (wb_valid),
                .wb_ready    (wb_ready),
                .wb_rob_idx  (wb_rob_idx),
                .wb_rd_addr  (wb_rd_addr),
                .wb_regf_we  (wb_regf_we),
                .wb_rd_data  (wb_rd_data),
                .wb_mem_addr (wb_mem_addr),
                .wb_is_store (wb_is_store)
        );

endmodule

/* testbench/dmem_model.sv */
`timescale 1ns/1ps

module dmem_model (
        input  logic        clk,
        input  logic        rst,
        input  logic [31:0] addr,
        input  logic [3:0]  rmask,
        input  logic [3:0]  wmask,
        input  logic [31:0] wdata,
        output logic [31:0] rdata,
        output logic        resp
);

        // 64-byte window, indexed by the low address bits
        logic [7:0] mem [64];
        logic [5:0] base;
        logic       busy;
        int         wait_cnt;

        initial begin
                for (int a = 0; a < 64; a++)
                        mem[a] = 8'(a * 157 + 53);
                busy     = 1'b0;
                wait_cnt = 0;
                resp     = 1'b0;
                rdata    = '0;
        end

        // looks at the request a little after each edge, once it has settled
        always @(posedge clk) begin
                #1;
                base = {addr[5:2], 2'b00};
                if (rst || resp) begin
                        // masks are already down after the resp edge
                        resp = 1'b0;
                        busy = 1'b0;
                end else if (rmask != 4'h0 || wmask != 4'h0) begin
                        if (!busy) begin
                                busy     = 1'b1;
                                wait_cnt = $urandom_range(1, 4);
                        end else begin
                                wait_cnt = wait_cnt - 1;
                                if (wait_cnt == 0) begin
                                        for (int i = 0; i < 4; i++) begin
                                                rdata[8*i +: 8] = mem[base | 6'(i)];
                                                if (wmask[i])
                                                        mem[base | 6'(i)] = wdata[8*i +: 8];
                                        end
                                        resp = 1'b1;
                                end
                        end
                end
        end

endmodule

/* testbench/tb_lsu.sv */
`timescale 1ns/1ps

module tb_lsu
        import rv32i_lsu_pkg::*;
        ();

        localparam int          NUM_OPS  = 200;
        localparam int          CLK_NS   = 8;
        localparam logic [31:0] WIN_BASE = 32'h0000_2000;

        typedef struct packed {
                logic                 valid;
                logic [ROB_IDX_W-1:0] rob_idx;
                logic [4:0]           rd_addr;
                logic                 regf_we;
                logic [31:0]          rd_data;
                logic [31:0]          mem_addr;
                logic                 is_store;
        } wb_exp_t;

        typedef struct packed {
                logic        valid;
                logic [31:0] addr;
                logic [3:0]  rmask;
                logic [3:0]  wmask;
        } req_exp_t;

        logic                 clk = 1'b0;
        logic                 rst;
        logic                 iss_valid;
        logic                 iss_ready;
        logic [31:0]          iss_pc;
        logic [31:0]          iss_inst;
        logic [31:0]          iss_rs1_data;
        logic [31:0]          iss_rs2_data;
        logic [4:0]           iss_rd_addr;
        logic [ROB_IDX_W-1:0] iss_rob_idx;
        logic [31:0]          dmem_addr;
        logic [3:0]           dmem_rmask;
        logic [3:0]           dmem_wmask;
        logic [31:0]          dmem_wdata;
        logic [31:0]          dmem_rdata;
        logic                 dmem_resp;
        logic                 wb_valid;
        logic                 wb_ready;
        logic [ROB_IDX_W-1:0] wb_rob_idx;
        logic [4:0]           wb_rd_addr;
        logic                 wb_regf_we;
        logic [31:0]          wb_rd_data;
        logic [31:0]          wb_mem_addr;
        logic                 wb_is_store;

        // reference memory and the ops still expected, oldest first
        logic [7:0] ref_mem [64];
        wb_exp_t    exp_q [$];
        req_exp_t   req_q [$];
        wb_exp_t    exp_head;
        req_exp_t   req_head;
        logic       req_active;
        logic       wb_fire;
        int         q_cnt;
        int         done_cnt;
        logic       hs_prev;
        logic       wb_fire_prev;
        logic       was_active;
        logic       saw_full;

        lsu_top uut (.*);

        dmem_model mem (
                .clk   (clk),
                .rst   (rst),
                .addr  (dmem_addr),
                .rmask (dmem_rmask),
                .wmask (dmem_wmask),
                .wdata (dmem_wdata),
                .rdata (dmem_rdata),
                .resp  (dmem_resp)
        );

        always #(CLK_NS / 2) clk = ~clk;

        assign req_active = (dmem_rmask != 4'h0) || (dmem_wmask != 4'h0);
        assign wb_fire    = wb_valid && wb_ready;

        function automatic logic [7:0] fill_byte(input int a);
                return 8'(a * 157 + 53);
        endfunction

        task automatic abort_run(input string what);
                $display("%s", what);
                $display("Simulation failed");
                $fatal(1);
        endtask

        task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                                       input logic [63:0] act_v);
                abort_run($sformatf("FAIL %s: expected %0h, actual %0h", name, exp_v, act_v));
        endtask

        task automatic refresh_heads();
                if (exp_q.size() != 0)
                        exp_head = exp_q[0];
                else
                        exp_head = '0;
                if (req_q.size() != 0)
                        req_head = req_q[0];
                else
                        req_head = '0;
        endtask

        // expected request and result of one op, applied to the reference memory
        task automatic record_op(input logic is_store, input logic [2:0] funct3,
                                 input logic [4:0] rd, input logic [ROB_IDX_W-1:0] rob,
                                 input logic [31:0] eff, input logic [31:0] data);
                int          size;
                logic [3:0]  mask;
                logic [31:0] raw;
                wb_exp_t     w;
                req_exp_t    r;
                size = (funct3[1:0] == 2'b00) ? 1 : (funct3[1:0] == 2'b01) ? 2 : 4;
                mask = 4'((1 << size) - 1) << eff[1:0];
                raw  = '0;
                for (int i = 0; i < size; i++) begin
                        if (is_store)
                                ref_mem[6'(eff[5:0] + 6'(i))] = data[8*i +: 8];
                        raw[8*i +: 8] = ref_mem[6'(eff[5:0] + 6'(i))];
                end
                case (funct3)
                        3'b000:  raw = {{24{raw[7]}}, raw[7:0]};
                        3'b001:  raw = {{16{raw[15]}}, raw[15:0]};
                        default: ;
                endcase
                w.valid    = 1'b1;
                w.rob_idx  = rob;
                w.rd_addr  = is_store ? 5'd0 : rd;
                w.regf_we  = !is_store && (rd != 5'd0);
                w.rd_data  = is_store ? 32'd0 : raw;
                w.mem_addr = eff;
                w.is_store = is_store;
                r.valid    = 1'b1;
                r.addr     = {eff[31:2], 2'b00};
                r.rmask    = is_store ? 4'h0 : mask;
                r.wmask    = is_store ? mask : 4'h0;
                exp_q.push_back(w);
                req_q.push_back(r);
                refresh_heads();
        endtask

        // holds the op on the issue port until the queue takes it
        task automatic issue_op(input logic is_store, input logic [2:0] funct3,
                                input logic [4:0] rd, input logic [ROB_IDX_W-1:0] rob,
                                input logic [31:0] eff, input logic [31:0] data);
                int          imm;
                logic [11:0] imm12;
                imm          = int'($urandom_range(0, 127)) - 64;
                imm12        = 12'(imm);
                iss_rs1_data = eff - 32'(imm);
                iss_rs2_data = data;
                iss_rd_addr  = rd;
                iss_rob_idx  = rob;
                iss_pc       = iss_pc + 32'd4;
                if (is_store)
                        iss_inst = {imm12[11:5], 5'd2, 5'd1, funct3, imm12[4:0], 7'b0100011};
                else
                        iss_inst = {imm12, 5'd1, funct3, rd, 7'b0000011};
                iss_valid = 1'b1;
                while (!iss_ready) begin
                        @(posedge clk);
                        #1;
                end
                record_op(is_store, funct3, rd, rob, eff, data);
                @(posedge clk);
                #1;
                iss_valid = 1'b0;
        endtask

        initial begin
                logic        st;
                int          pick;
                logic [2:0]  f3;
                logic [31:0] eff;
                void'($urandom(32'h6e86_1f6e));
                rst          = 1'b1;
                iss_valid    = 1'b0;
                iss_pc       = 32'h0000_1000;
                iss_inst     = '0;
                iss_rs1_data = '0;
                iss_rs2_data = '0;
                iss_rd_addr  = '0;
                iss_rob_idx  = '0;
                for (int a = 0; a < 64; a++)
                        ref_mem[a] = fill_byte(a);
                refresh_heads();
                repeat (10) @(posedge clk);
                #1;
                rst = 1'b0;

                for (int n = 0; n < NUM_OPS; n++) begin
                        if ($urandom_range(0, 3) == 0) begin
                                @(posedge clk);
                                #1;
                        end
                        st   = ($urandom_range(0, 9) < 4);
                        pick = $urandom_range(0, 4);
                        // stores use b, h, w; loads add bu and hu
                        if (st)
                                f3 = 3'(pick % 3);
                        else
                                f3 = (pick < 3) ? 3'(pick) : 3'(pick + 1);
                        eff = WIN_BASE + 32'($urandom_range(0, 15) * 4);
                        if (f3[1:0] == 2'b00)
                                eff = eff + 32'($urandom_range(0, 3));
                        else if (f3[1:0] == 2'b01)
                                eff = eff + 32'($urandom_range(0, 1) * 2);
                        issue_op(st, f3, 5'($urandom_range(0, 7)), ROB_IDX_W'(n), eff,
                                 $urandom());
                end

                while (done_cnt < NUM_OPS)
                        @(posedge clk);
                if (!saw_full) begin
                        abort_run("issue queue never filled under writeback stalls");
                end else begin
                        $display("Simulation completed successfully");
                        $finish;
                end
        end

        // writeback side, long stall every 160 cycles to back up the pipe
        initial begin
                int cyc;
                cyc      = 0;
                wb_ready = 1'b0;
                forever begin
                        @(posedge clk);
                        #1;
                        if (rst) begin
                                wb_ready = 1'b0;
                        end else begin
                                cyc++;
                                if (cyc % 160 >= 120)
                                        wb_ready = 1'b0;
                                else
                                        wb_ready = ($urandom_range(0, 3) != 0);
                        end
                end
        end

        // bookkeeping after the edge has settled and inputs are driven
        initial begin
                q_cnt        = 0;
                done_cnt     = 0;
                hs_prev      = 1'b0;
                wb_fire_prev = 1'b0;
                was_active   = 1'b0;
                saw_full     = 1'b0;
                forever begin
                        @(posedge clk);
                        #2;
                        if (rst) begin
                                q_cnt        = 0;
                                hs_prev      = 1'b0;
                                wb_fire_prev = 1'b0;
                                was_active   = 1'b0;
                        end else begin
                                if (wb_fire_prev && exp_q.size() != 0) begin
                                        void'(exp_q.pop_front());
                                        done_cnt++;
                                end
                                if (was_active && !req_active && req_q.size() != 0)
                                        void'(req_q.pop_front());
                                // queue fill after the last edge
                                q_cnt = q_cnt + int'(hs_prev) - int'(req_active && !was_active);
                                refresh_heads();
                                if (!iss_ready)
                                        saw_full = 1'b1;
                                hs_prev      = iss_valid && iss_ready;
                                wb_fire_prev = wb_fire;
                                was_active   = req_active;
                        end
                end
        end

        initial begin
                #(NUM_OPS * 40 * CLK_NS);
                abort_run("watchdog timeout, not every issued operation completed");
        end

        a_reset_idle: assert property (@(posedge clk)
                $past(rst) |-> {wb_valid, dmem_rmask, dmem_wmask, !iss_ready} == 10'd0)
                else report_mismatch("reset {wb_valid,rmask,wmask,!iss_ready}", 64'd0,
                                64'($sampled({wb_valid, dmem_rmask, dmem_wmask, !iss_ready})));

        a_req_known: assert property (@(posedge clk) disable iff (rst)
                req_active |-> req_head.valid)
                else abort_run("memory request with no operation in flight");

        a_req_addr: assert property (@(posedge clk) disable iff (rst)
                req_active |-> dmem_addr == req_head.addr)
                else report_mismatch("request address", 64'($sampled(req_head.addr)),
                                64'($sampled(dmem_addr)));

        a_req_rmask: assert property (@(posedge clk) disable iff (rst)
                req_active |-> dmem_rmask == req_head.rmask)
                else report_mismatch("request read mask", 64'($sampled(req_head.rmask)),
                                64'($sampled(dmem_rmask)));

        a_req_wmask: assert property (@(posedge clk) disable iff (rst)
                req_active |-> dmem_wmask == req_head.wmask)
                else report_mismatch("request write mask", 64'($sampled(req_head.wmask)),
                                64'($sampled(dmem_wmask)));

        a_req_hold: assert property (@(posedge clk) disable iff (rst)
                req_active && !dmem_resp |=>
                $stable({dmem_addr, dmem_rmask, dmem_wmask, dmem_wdata}))
                else abort_run("memory request changed before its response");

        a_wb_known: assert property (@(posedge clk) disable iff (rst)
                wb_valid |-> exp_head.valid)
                else abort_run("writeback result with no operation outstanding");

        a_wb_rob: assert property (@(posedge clk) disable iff (rst)
                wb_fire |-> wb_rob_idx == exp_head.rob_idx)
                else report_mismatch("order rob_idx", 64'($sampled(exp_head.rob_idx)),
                                64'($sampled(wb_rob_idx)));

        a_wb_rd: assert property (@(posedge clk) disable iff (rst)
                wb_fire |-> wb_rd_addr == exp_head.rd_addr)
                else report_mismatch("order rd_addr", 64'($sampled(exp_head.rd_addr)),
                                64'($sampled(wb_rd_addr)));

        a_wb_addr: assert property (@(posedge clk) disable iff (rst)
                wb_fire |-> wb_mem_addr == exp_head.mem_addr)
                else report_mismatch("order mem_addr", 64'($sampled(exp_head.mem_addr)),
                                64'($sampled(wb_mem_addr)));

        a_wb_store: assert property (@(posedge clk) disable iff (rst)
                wb_fire |-> wb_is_store == exp_head.is_store)
                else report_mismatch("order is_store", 64'($sampled(exp_head.is_store)),
                                64'($sampled(wb_is_store)));

        a_wb_we: assert property (@(posedge clk) disable iff (rst)
                wb_fire |-> wb_regf_we == exp_head.regf_we)
                else report_mismatch("regf_we", 64'($sampled(exp_head.regf_we)),
                                64'($sampled(wb_regf_we)));

        a_wb_data: assert property (@(posedge clk) disable iff (rst)
                wb_fire && !exp_head.is_store |-> wb_rd_data == exp_head.rd_data)
                else report_mismatch("load data", 64'($sampled(exp_head.rd_data)),
                                64'($sampled(wb_rd_data)));

        a_wb_hold: assert property (@(posedge clk) disable iff (rst)
                wb_valid && !wb_ready |=> wb_valid && $stable({wb_rob_idx, wb_rd_addr,
                wb_regf_we, wb_rd_data, wb_mem_addr, wb_is_store}))
                else abort_run("writeback fields moved while the result was stalled");

        a_queue_full: assert property (@(posedge clk) disable iff (rst)
                iss_ready == (q_cnt < QUEUE_DEPTH))
                else report_mismatch("iss_ready with queue fill",
                                64'($sampled(q_cnt < QUEUE_DEPTH)),
                                64'($sampled(iss_ready)));

endmodule

/* vlog.f */
hdl/rv32i_lsu_pkg.sv
hdl/lsu_ifs.sv
hdl/mem_issue_queue.sv
hdl/mem_unit.sv
hdl/wb_buffer.sv
hdl/lsu_top.sv
testbench/dmem_model.sv
testbench/tb_lsu.sv

/* run_sim.sh */
#!/bin/sh
# build the LSU testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
        --top-module tb_lsu -f vlog.f -o tb_lsu
if [ $? -ne 0 ]; then
        echo "verilator build failed"
        exit 1
fi

./obj_dir/tb_lsu > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
        echo "simulation exited with status $status"
        exit 1
fi

if grep -q "Simulation failed" "$log"; then
        exit 1
fi
exit 0
